/* Makefile */
# Verilator build and run for the PHY management testbench

VERILATOR ?= verilator
TOP       ?= phy_mgmt_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
FLIST     ?= sim.f
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* logic/mdio_master.sv */
`timescale 1ns/10ps

module mdio_master #(
	parameter int MDC_HALF = phy_mgmt_pkg::DEF_MDC_HALF
) (
	input  logic                    clk_125mhz,
	input  logic                    arst_n,
	input  phy_mgmt_pkg::mdio_req_t req,
	output phy_mgmt_pkg::mdio_rsp_t rsp,
	output logic                    mdc,
	output logic                    mdio_o,
	output logic                    mdio_oe,
	input  logic                    mdio_i
);

	import phy_mgmt_pkg::*;

	localparam int DATA_BITS = 16;
	localparam int HALVES    = 2 * MDIO_FRAME_BITS;	// MDC half periods per frame
	localparam int HALF_W    = $clog2(HALVES);
	localparam int DIV_W     = $clog2(MDC_HALF + 1);

	// Second turnaround bit, where a read hands the line to the PHY
	localparam int TA2_BIT   = MDIO_FRAME_BITS - DATA_BITS - 1;

	logic                       wr_q;	// Delayed copy of req.wr
	logic                       rd_q;	// Delayed copy of req.rd
	logic                       start_wr;
	logic                       start_rd;
	logic                       busy_q;
	logic                       op_rd_q;	// Frame in flight is a read
	logic [DIV_W-1:0]           div_q;	// Clocks into current half period
	logic [HALF_W-1:0]          half_q;	// Half period index within frame
	logic [HALF_W-1:0]          half_nxt;
	logic                       half_end;	// Last clock of a half period
	logic                       frame_done;
	logic [MDIO_FRAME_BITS-1:0] frame_new;
	logic [MDIO_FRAME_BITS-1:0] frame_q;	// MSB is on the wire
	logic [DATA_BITS-1:0]       rx_shift_q;
	logic [DATA_BITS-1:0]       rd_data_q;

	////////////////////////////////////////////////////////////
	// Request edge detection

	always_ff @(posedge clk_125mhz or negedge arst_n) begin
		if (!arst_n) begin
			wr_q <= 1'b0;
			rd_q <= 1'b0;
		end else begin
			wr_q <= req.wr;	// Tracked while busy too, so edges get dropped
			rd_q <= req.rd;
		end
	end

	assign start_wr = !busy_q && req.wr && !wr_q;
	assign start_rd = !busy_q && req.rd && !rd_q && !start_wr;	// Write wins a tie

	// Whole frame, preamble first
	assign frame_new = {
		{MDIO_PREAMBLE_BITS{1'b1}},
		2'b01,	// Start
		start_wr ? MDIO_OP_WRITE : MDIO_OP_READ,
		req.phy_addr,
		req.reg_addr,
		2'b10,	// Turnaround
		start_wr ? req.wr_data : {DATA_BITS{1'b1}}	// Read data slot idles high
	};

	////////////////////////////////////////////////////////////
	// MDC divider and bit timing

	assign half_end   = (div_q == DIV_W'(MDC_HALF - 1));
	assign half_nxt   = half_q + 1'b1;
	assign frame_done = busy_q && half_end && (half_q == HALF_W'(HALVES - 1));

	always_ff @(posedge clk_125mhz or negedge arst_n) begin
		if (!arst_n) begin
			busy_q  <= 1'b0;
			op_rd_q <= 1'b0;
			div_q   <= '0;
			half_q  <= '0;
			mdc     <= 1'b0;
			mdio_oe <= 1'b0;
			frame_q <= '1;	// Line idles high
		end else if (!busy_q) begin
			if (start_wr || start_rd) begin
				busy_q  <= 1'b1;
				op_rd_q <= start_rd;
				div_q   <= '0;
				half_q  <= '0;
				mdc     <= 1'b0;
				mdio_oe <= 1'b1;	// Master owns the line up to turnaround
				frame_q <= frame_new;	// Captures address and data
			end
		end else if (!half_end) begin
			div_q <= div_q + 1'b1;
		end else begin
			div_q  <= '0;
			half_q <= half_nxt;
			mdc    <= ~mdc;

			// Odd half ending means MDC falls, so present the next bit
			if (half_q[0]) begin
				frame_q <= {frame_q[MDIO_FRAME_BITS-2:0], 1'b1};
				if (op_rd_q && half_nxt == HALF_W'(2 * TA2_BIT))
					mdio_oe <= 1'b0;	// PHY drives from here on
			end

			if (frame_done) begin
				busy_q  <= 1'b0;	// MDC is low again after this edge
				mdio_oe <= 1'b0;
			end
		end
	end

	assign mdio_o = frame_q[MDIO_FRAME_BITS-1];

	////////////////////////////////////////////////////////////
	// Read data capture

	// Sample as MDC rises, last 16 samples are the data bits
	always_ff @(posedge clk_125mhz or negedge arst_n) begin
		if (!arst_n)
			rx_shift_q <= '0;
		else if (busy_q && half_end && !half_q[0] && op_rd_q)
			rx_shift_q <= {rx_shift_q[DATA_BITS-2:0], mdio_i};
	end

	// Result only moves at the end of a read
	always_ff @(posedge clk_125mhz or negedge arst_n) begin
		if (!arst_n)
			rd_data_q <= '0;
		else if (frame_done && op_rd_q)
			rd_data_q <= rx_shift_q;
	end

	assign rsp.rd_data = rd_data_q;
	assign rsp.busy    = busy_q;

endmodule

/* logic/phy_mgmt_pkg.sv */
package phy_mgmt_pkg;

	////////////////////////////////////////////////////////////
	// Management request and response

	// One PHY's register access request
	typedef struct packed {
		logic [4:0]  phy_addr;	// PHY address on the bus
		logic [4:0]  reg_addr;	// Clause 22 register number
		logic [15:0] wr_data;	// Value for a write
		logic        wr;	// Level, rising edge starts a write
		logic        rd;	// Level, rising edge starts a read
	} mdio_req_t;

	// One PHY's access result
	typedef struct packed {
		logic [15:0] rd_data;	// Last read value
		logic        busy;	// Frame in flight
	} mdio_rsp_t;

	////////////////////////////////////////////////////////////
	// Clause 22 frame layout

	localparam int MDIO_PREAMBLE_BITS = 32;	// All ones
	localparam int MDIO_FRAME_BITS    = 64;	// Preamble through data

	// Opcodes, sent right after the 01 start pattern
	localparam logic [1:0] MDIO_OP_WRITE = 2'b01;
	localparam logic [1:0] MDIO_OP_READ  = 2'b10;

	////////////////////////////////////////////////////////////
	// Top level defaults

	localparam int DEF_NUM_PHYS     = 4;	// One onboard, three external
	localparam int DEF_RESET_CYCLES = 65535;	// About 0.5 ms at 125 MHz
	localparam int DEF_MDC_HALF     = 25;	// 2.5 MHz MDC

	// Long enough for the eye to catch a single packet
	localparam int DEF_ACT_STRETCH  = 16777215;

endpackage

/* logic/phy_mgmt_top.sv */
`timescale 1ns/10ps

module phy_mgmt_top #(
	parameter int NUM_PHYS     = phy_mgmt_pkg::DEF_NUM_PHYS,
	parameter int RESET_CYCLES = phy_mgmt_pkg::DEF_RESET_CYCLES,
	parameter int MDC_HALF     = phy_mgmt_pkg::DEF_MDC_HALF,
	parameter int ACT_STRETCH  = phy_mgmt_pkg::DEF_ACT_STRETCH
) (
	input  logic                    clk_125mhz,
	input  logic                    arst_n,

	// Register access, one slot per PHY
	input  phy_mgmt_pkg::mdio_req_t mdio_req [NUM_PHYS],
	output phy_mgmt_pkg::mdio_rsp_t mdio_rsp [NUM_PHYS],

	// Management bus, pad buffer is outside
	output logic [NUM_PHYS-1:0]     mdc,
	output logic [NUM_PHYS-1:0]     mdio_o,
	output logic [NUM_PHYS-1:0]     mdio_oe,
	input  logic [NUM_PHYS-1:0]     mdio_i,

	// MAC status
	input  logic [NUM_PHYS-1:0]     link_up,
	input  logic [NUM_PHYS-1:0]     rx_start,	// Pulse per received frame

	// Board outputs
	output logic [NUM_PHYS-1:0]     phy_rst_n,
	output logic [NUM_PHYS-1:0]     link_led,
	output logic [NUM_PHYS-1:0]     act_led
);

	////////////////////////////////////////////////////////////
	// PHY reset

	phy_reset_seq #(
		.NUM_PHYS     (NUM_PHYS),
		.RESET_CYCLES (RESET_CYCLES)
	) i_phy_reset_seq (
		.clk_125mhz (clk_125mhz),
		.arst_n     (arst_n),
		.phy_rst_n  (phy_rst_n)
	);

	////////////////////////////////////////////////////////////
	// Management masters

	// Independent bus per PHY, no sharing between ports
	for (genvar i = 0; i < NUM_PHYS; i++) begin : g_mdio
		mdio_master #(
			.MDC_HALF (MDC_HALF)
		) i_mdio_master (
			.clk_125mhz (clk_125mhz),
			.arst_n     (arst_n),
			.req        (mdio_req[i]),
			.rsp        (mdio_rsp[i]),
			.mdc        (mdc[i]),
			.mdio_o     (mdio_o[i]),
			.mdio_oe    (mdio_oe[i]),
			.mdio_i     (mdio_i[i])
		);
	end

	////////////////////////////////////////////////////////////
	// Port LEDs

	port_led_driver #(
		.NUM_PHYS    (NUM_PHYS),
		.ACT_STRETCH (ACT_STRETCH)
	) i_port_led_driver (
		.clk_125mhz (clk_125mhz),
		.arst_n     (arst_n),
		.link_up    (link_up),
		.rx_start   (rx_start),
		.link_led   (link_led),
		.act_led    (act_led)
	);

endmodule

/* logic/phy_reset_seq.sv */
`timescale 1ns/10ps

module phy_reset_seq #(
	parameter int NUM_PHYS     = phy_mgmt_pkg::DEF_NUM_PHYS,
	parameter int RESET_CYCLES = phy_mgmt_pkg::DEF_RESET_CYCLES
) (
	input  logic                clk_125mhz,
	input  logic                arst_n,
	output logic [NUM_PHYS-1:0] phy_rst_n
);

	localparam int CNT_W = $clog2(RESET_CYCLES + 1);

	logic [CNT_W-1:0] cnt_q;	// Clocks since system reset
	logic             done_q;	// PHYs out of reset

	////////////////////////////////////////////////////////////
	// Delayed PHY bring-up

	// Counter stops once the PHYs are released
	always_ff @(posedge clk_125mhz or negedge arst_n) begin
		if (!arst_n) begin
			cnt_q  <= '0;
			done_q <= 1'b0;
		end else if (!done_q) begin
			if (cnt_q == CNT_W'(RESET_CYCLES - 1))
				done_q <= 1'b1;	// Edge number RESET_CYCLES
			else
				cnt_q <= cnt_q + 1'b1;
		end
	end

	// All ports leave reset together
	assign phy_rst_n = {NUM_PHYS{done_q}};

endmodule

/* logic/port_led_driver.sv */
`timescale 1ns/10ps

module port_led_driver #(
	parameter int NUM_PHYS    = phy_mgmt_pkg::DEF_NUM_PHYS,
	parameter int ACT_STRETCH = phy_mgmt_pkg::DEF_ACT_STRETCH
) (
	input  logic                clk_125mhz,
	input  logic                arst_n,
	input  logic [NUM_PHYS-1:0] link_up,
	input  logic [NUM_PHYS-1:0] rx_start,
	output logic [NUM_PHYS-1:0] link_led,
	output logic [NUM_PHYS-1:0] act_led
);

	localparam int CNT_W = $clog2(ACT_STRETCH + 1);

	////////////////////////////////////////////////////////////
	// Link LEDs

	always_ff @(posedge clk_125mhz or negedge arst_n) begin
		if (!arst_n)
			link_led <= '0;
		else
			link_led <= link_up;	// One cycle behind the MAC
	end

	////////////////////////////////////////////////////////////
	// Activity stretchers

	for (genvar i = 0; i < NUM_PHYS; i++) begin : g_act
		logic [CNT_W-1:0] act_cnt_q;	// Clocks of blink left

		// Every frame start reloads, so bursts keep the LED lit
		always_ff @(posedge clk_125mhz or negedge arst_n) begin
			if (!arst_n)
				act_cnt_q <= '0;
			else if (rx_start[i])
				act_cnt_q <= CNT_W'(ACT_STRETCH);
			else if (act_cnt_q != '0)
				act_cnt_q <= act_cnt_q - 1'b1;
		end

		// Lit while any count remains
		assign act_led[i] = (act_cnt_q != '0);
	end

endmodule

/* sim.f */
logic/phy_mgmt_pkg.sv
logic/phy_reset_seq.sv
logic/mdio_master.sv
logic/port_led_driver.sv
logic/phy_mgmt_top.sv
verification/mdio_phy_model.sv
verification/phy_mgmt_props.sv
verification/phy_mgmt_tb.sv

/* verification/mdio_phy_model.sv */
`timescale 1ns/10ps

module mdio_phy_model #(
	parameter int PHY_ADDR = 0
) (
	input  logic arst_n,
	input  logic mdc,
	input  logic mdio_o,
	input  logic mdio_oe,
	output logic mdio_i
);

	import phy_mgmt_pkg::*;

	logic [15:0] regs [32];	// Clause 22 register file
	logic [63:0] hdr;	// Bits seen so far, newest in bit 0
	logic [5:0]  cnt;	// Index of the next bit on the wire
	logic        rd_act;	// Read addressed to this PHY
	logic [15:0] rd_val;
	logic [63:0] frame;	// Whole frame at its last bit

	////////////////////////////////////////////////////////////
	// Sample on rising MDC

	always @(posedge mdc or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			hdr <= '0;
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else begin
			frame = {hdr[62:0], mdio_o};
			hdr   <= frame;
			cnt   <= cnt + 1'b1;	// 64 rises per frame, wraps to 0
			// Last bit, commit a write that is ours
			if (cnt == 6'd63 && frame[29:28] == MDIO_OP_WRITE &&
					frame[27:23] == 5'(PHY_ADDR))
				regs[frame[22:18]] <= frame[15:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Drive on falling MDC

	always @(negedge mdc or negedge arst_n) begin
		if (!arst_n) begin
			rd_act <= 1'b0;
			rd_val <= '0;
			mdio_i <= 1'b1;	// Pull-up
		end else begin
			if (cnt == 6'd47) begin
				// Op, PHY and register are in, bits 34 to 45
				rd_act <= (hdr[12:11] == MDIO_OP_READ) && (hdr[10:6] == 5'(PHY_ADDR));
				rd_val <= regs[hdr[5:1]];
			end
			if (cnt == 6'd47 && hdr[12:11] == MDIO_OP_READ &&
					hdr[10:6] == 5'(PHY_ADDR) && !mdio_oe)
				mdio_i <= 1'b0;	// Turnaround zero
			else if (cnt >= 6'd48 && rd_act && !mdio_oe)
				mdio_i <= rd_val[6'd63 - cnt];	// MSB first
			else
				mdio_i <= 1'b1;
		end
	end

endmodule

/* verification/phy_mgmt_props.sv */
`timescale 1ns/10ps

module phy_mgmt_props #(
	parameter int NUM_PHYS = 4,
	parameter int MDC_HALF = 2
) (
	input logic                    clk_125mhz,
	input logic                    arst_n,
	input logic [NUM_PHYS-1:0]     phy_rst_n,
	input logic [NUM_PHYS-1:0]     mdc,
	input phy_mgmt_pkg::mdio_rsp_t mdio_rsp [NUM_PHYS]
);

	import phy_mgmt_pkg::*;

	localparam int FRAME_CYCLES = MDIO_FRAME_BITS * 2 * MDC_HALF;

	int fail_cnt = 0;	// Assertion failures so far

	// Released PHYs stay released
	a_rst_hold: assert property (@(posedge clk_125mhz) disable iff (!arst_n)
		(&phy_rst_n) |=> (&phy_rst_n))
		else begin
			fail_cnt++;
			$error("phy_rst_n fell after release");
		end

	for (genvar i = 0; i < NUM_PHYS; i++) begin : g_port
		logic [15:0] busy_cnt;	// Cycles busy has been high

		always @(posedge clk_125mhz or negedge arst_n) begin
			if (!arst_n)
				busy_cnt <= '0;
			else if (mdio_rsp[i].busy)
				busy_cnt <= busy_cnt + 1'b1;
			else
				busy_cnt <= '0;
		end

		a_mdc_idle: assert property (@(posedge clk_125mhz) disable iff (!arst_n)
			!mdio_rsp[i].busy |-> !mdc[i])
			else begin
				fail_cnt++;
				$error("mdc high while idle on port %0d", i);
			end

		// Never longer than one frame
		a_busy_max: assert property (@(posedge clk_125mhz) disable iff (!arst_n)
			mdio_rsp[i].busy |-> (busy_cnt < 16'(FRAME_CYCLES)))
			else begin
				fail_cnt++;
				$error("busy too long on port %0d", i);
			end

		// And never shorter
		a_busy_len: assert property (@(posedge clk_125mhz) disable iff (!arst_n)
			$fell(mdio_rsp[i].busy) |-> (busy_cnt == 16'(FRAME_CYCLES)))
			else begin
				fail_cnt++;
				$error("busy length wrong on port %0d", i);
			end
	end

endmodule

bind phy_mgmt_top phy_mgmt_props #(
	.NUM_PHYS (NUM_PHYS),
	.MDC_HALF (MDC_HALF)
) i_phy_mgmt_props (
	.clk_125mhz (clk_125mhz),
	.arst_n     (arst_n),
	.phy_rst_n  (phy_rst_n),
	.mdc        (mdc),
	.mdio_rsp   (mdio_rsp)
);

/* verification/phy_mgmt_tb.sv */
`timescale 1ns/10ps

module phy_mgmt_tb;

	import phy_mgmt_pkg::*;

	localparam int NUM_PHYS     = 4;
	localparam int RESET_CYCLES = 20;
	localparam int MDC_HALF     = 2;
	localparam int ACT_STRETCH  = 10;
	localparam int FRAME_CYCLES = MDIO_FRAME_BITS * 2 * MDC_HALF;

	logic                clk_125mhz = 1'b0;
	logic                arst_n;
	mdio_req_t           mdio_req [NUM_PHYS];
	mdio_rsp_t           mdio_rsp [NUM_PHYS];
	logic [NUM_PHYS-1:0] mdc, mdio_o, mdio_oe, mdio_i;
	logic [NUM_PHYS-1:0] link_up, rx_start;
	logic [NUM_PHYS-1:0] phy_rst_n, link_led, act_led;

	// Shadow of every model register file
	logic [15:0] shadow  [NUM_PHYS][32];
	logic        written [NUM_PHYS][32];

	// Results waiting for the checker
	logic [31:0] got_q [$];
	logic [31:0] exp_q [$];
	string       tag_q [$];

	int errors = 0;
	int checks = 0;
	int tests  = 0;

	always #4 clk_125mhz = ~clk_125mhz;	// 125 MHz

	phy_mgmt_top #(
		.NUM_PHYS     (NUM_PHYS),
		.RESET_CYCLES (RESET_CYCLES),
		.MDC_HALF     (MDC_HALF),
		.ACT_STRETCH  (ACT_STRETCH)
	) i_phy_mgmt_top (.*);

	for (genvar i = 0; i < NUM_PHYS; i++) begin : g_phy
		mdio_phy_model #(.PHY_ADDR(i)) i_mdio_phy_model (
			.arst_n  (arst_n),
			.mdc     (mdc[i]),
			.mdio_o  (mdio_o[i]),
			.mdio_oe (mdio_oe[i]),
			.mdio_i  (mdio_i[i])
		);
	end

	////////////////////////////////////////////////////////////
	// Reference and checking

	// Last value written, else zero
	function automatic logic [15:0] ref_read(int port, int rgn);
		return written[port][rgn] ? shadow[port][rgn] : 16'h0000;
	endfunction

	task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic post(string name, logic [31:0] got, logic [31:0] exp);
		tag_q.push_back(name);
		got_q.push_back(got);
		exp_q.push_back(exp);
	endtask

	// Checker drains posted results
	always @(negedge clk_125mhz) begin
		while (got_q.size() > 0)
			compare(tag_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
	end

	task automatic end_test(string name, int err_before);
		int n;
		n = 0;
		while (got_q.size() > 0 && n < 10) begin
			@(negedge clk_125mhz);
			n++;
		end
		if (got_q.size() > 0) begin
			errors++;
			$display("Checker did not drain its queue in %s", name);
		end
		tests++;
		$display("Test %s finished with %0d errors", name, errors - err_before);
	endtask

	////////////////////////////////////////////////////////////
	// MDIO helpers

	// Waits out one frame, returns its busy length
	task automatic run_frame(int port, output int len);
		int n;
		len = 0;
		n = 0;
		while (!mdio_rsp[port].busy && n < 10) begin
			@(negedge clk_125mhz);
			n++;
		end
		if (!mdio_rsp[port].busy) begin
			errors++;
			$display("Port %0d never went busy", port);
			return;
		end
		while (mdio_rsp[port].busy && len < 2 * FRAME_CYCLES) begin
			@(negedge clk_125mhz);
			len++;
		end
		if (mdio_rsp[port].busy) begin
			errors++;
			$display("Port %0d stuck busy", port);
		end
	endtask

	task automatic write_reg(int port, int rgn, logic [15:0] data);
		int len;
		mdio_req[port].phy_addr = 5'(port);
		mdio_req[port].reg_addr = 5'(rgn);
		mdio_req[port].wr_data  = data;
		mdio_req[port].wr       = 1'b1;
		@(negedge clk_125mhz);
		run_frame(port, len);
		post("busy_len", 32'(len), 32'(FRAME_CYCLES));
		shadow[port][rgn]  = data;
		written[port][rgn] = 1'b1;
		mdio_req[port].wr = 1'b0;
		@(negedge clk_125mhz);
	endtask

	task automatic read_reg(int port, int rgn, output logic [15:0] data);
		int len;
		mdio_req[port].phy_addr = 5'(port);
		mdio_req[port].reg_addr = 5'(rgn);
		mdio_req[port].rd       = 1'b1;
		@(negedge clk_125mhz);
		run_frame(port, len);
		post("busy_len", 32'(len), 32'(FRAME_CYCLES));
		data = mdio_rsp[port].rd_data;
		mdio_req[port].rd = 1'b0;
		@(negedge clk_125mhz);
	endtask

	// Counts cycles act_led stays lit after a pulse
	task automatic act_pulse(int port, output int lit);
		rx_start[port] = 1'b1;
		@(negedge clk_125mhz);
		rx_start[port] = 1'b0;
		lit = 0;
		while (act_led[port] && lit < 4 * ACT_STRETCH) begin
			@(negedge clk_125mhz);
			lit++;
		end
		if (act_led[port]) begin
			errors++;
			$display("Port %0d activity LED stuck lit", port);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		int          e0, len, lit, rgn;
		logic [15:0] data, rdv, prev;
		logic [3:0]  lnk;
		bit          extra;

		void'($urandom(72));
		arst_n   = 1'b0;
		link_up  = '0;
		rx_start = '0;
		for (int p = 0; p < NUM_PHYS; p++) begin
			mdio_req[p] = '0;
			for (int r = 0; r < 32; r++) begin
				shadow[p][r]  = '0;
				written[p][r] = 1'b0;
			end
		end

		// 1: PHY reset release
		e0 = errors;
		repeat (4) @(negedge clk_125mhz);
		post("phy_rst_n", 32'(phy_rst_n), 32'h0);
		arst_n = 1'b1;
		for (int k = 1; k <= RESET_CYCLES; k++) begin
			@(negedge clk_125mhz);
			post("phy_rst_n", 32'(phy_rst_n), (k < RESET_CYCLES) ? 32'h0 : 32'hf);
		end
		end_test("reset_release", e0);

		// 2: write then read per PHY
		e0 = errors;
		for (int p = 0; p < NUM_PHYS; p++) begin
			rgn  = $urandom % 32;
			data = 16'($urandom);
			write_reg(p, rgn, data);
			read_reg(p, rgn, rdv);
			post("rd_data", 32'(rdv), 32'(ref_read(p, rgn)));
			read_reg(p, (rgn + 1) % 32, rdv);	// Never written
			post("rd_data", 32'(rdv), 32'(ref_read(p, (rgn + 1) % 32)));
		end
		end_test("write_read", e0);

		// 3: edges while busy are dropped
		e0 = errors;
		prev = mdio_rsp[0].rd_data;
		mdio_req[0].phy_addr = 5'd0;
		mdio_req[0].reg_addr = 5'd5;
		mdio_req[0].wr_data  = 16'ha5c3;
		mdio_req[0].wr       = 1'b1;
		@(negedge clk_125mhz);
		repeat (20) @(negedge clk_125mhz);
		mdio_req[0].rd = 1'b1;	// Read edge mid frame
		mdio_req[0].wr = 1'b0;
		@(negedge clk_125mhz);
		mdio_req[0].reg_addr = 5'd6;
		mdio_req[0].wr_data  = 16'h1234;
		mdio_req[0].wr       = 1'b1;	// Second write edge
		run_frame(0, len);
		post("busy_len", 32'(len + 21), 32'(FRAME_CYCLES));	// 21 busy cycles already gone
		shadow[0][5]  = 16'ha5c3;
		written[0][5] = 1'b1;
		extra = 1'b0;
		repeat (20) begin
			@(negedge clk_125mhz);
			extra |= mdio_rsp[0].busy;
		end
		post("busy", 32'(extra), 32'h0);
		post("rd_data", 32'(mdio_rsp[0].rd_data), 32'(prev));
		mdio_req[0].wr = 1'b0;
		mdio_req[0].rd = 1'b0;
		@(negedge clk_125mhz);
		read_reg(0, 5, rdv);
		post("rd_data", 32'(rdv), 32'(ref_read(0, 5)));
		read_reg(0, 6, rdv);
		post("rd_data", 32'(rdv), 32'(ref_read(0, 6)));
		end_test("busy_drop", e0);

		// 4: held wr writes only once
		e0 = errors;
		mdio_req[1].phy_addr = 5'd1;
		mdio_req[1].reg_addr = 5'd7;
		mdio_req[1].wr_data  = 16'hbeef;
		mdio_req[1].wr       = 1'b1;
		@(negedge clk_125mhz);
		run_frame(1, len);
		post("busy_len", 32'(len), 32'(FRAME_CYCLES));
		shadow[1][7]  = 16'hbeef;
		written[1][7] = 1'b1;
		mdio_req[1].wr_data = 16'hdead;	// Must never reach the PHY
		extra = 1'b0;
		repeat (3 * FRAME_CYCLES) begin
			@(negedge clk_125mhz);
			extra |= mdio_rsp[1].busy;
		end
		post("busy", 32'(extra), 32'h0);
		mdio_req[1].wr = 1'b0;
		@(negedge clk_125mhz);
		read_reg(1, 7, rdv);
		post("rd_data", 32'(rdv), 32'(ref_read(1, 7)));
		write_reg(1, 7, 16'h0f0f);
		read_reg(1, 7, rdv);
		post("rd_data", 32'(rdv), 32'(ref_read(1, 7)));
		end_test("held_write", e0);

		// 5: LEDs
		e0 = errors;
		repeat (4) begin
			lnk = 4'($urandom);
			link_up = lnk;
			@(negedge clk_125mhz);
			post("link_led", 32'(link_led), 32'(lnk));
		end
		act_pulse(2, lit);
		post("act_lit", 32'(lit), 32'(ACT_STRETCH));
		rx_start[2] = 1'b1;
		@(negedge clk_125mhz);
		rx_start[2] = 1'b0;
		repeat (4) @(negedge clk_125mhz);
		act_pulse(2, lit);	// Retrigger mid blink
		post("act_lit", 32'(lit), 32'(ACT_STRETCH));
		post("act_led", 32'(act_led), 32'h0);
		post("phy_rst_n", 32'(phy_rst_n), 32'hf);
		end_test("leds", e0);

		// Bound assertion failures count too
		errors += i_phy_mgmt_top.i_phy_mgmt_props.fail_cnt;

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
